//--- dv/pipeline_stim.txt
# P <instr hex> | E <test> <addr hex> <data hex> | R <0 fixed, 1 random latency>
# Program words load from address 0, data lives at 0x200 (x10)
R 1
P 20000513  # addi x10, x0, 0x200
P 00700093  # addi x1, x0, 7
P ffd00113  # addi x2, x0, -3
P 002081b3  # add  x3, x1, x2
P 00352023  # sw   x3, 0(x10)
P 40208233  # sub  x4, x1, x2
P 00452223  # sw   x4, 4(x10)
P 0020f2b3  # and  x5, x1, x2
P 00552423  # sw   x5, 8(x10)
P 0020e333  # or   x6, x1, x2
P 00652623  # sw   x6, 12(x10)
P 0020c3b3  # xor  x7, x1, x2
P 00752823  # sw   x7, 16(x10)
P 00112433  # slt  x8, x2, x1
P 00852a23  # sw   x8, 20(x10)
P 123455b7  # lui  x11, 0x12345
P fff58593  # addi x11, x11, -1
P 00b52c23  # sw   x11, 24(x10)
P fffff637  # lui  x12, 0xfffff
P 7ff60613  # addi x12, x12, 0x7ff
P 00c52e23  # sw   x12, 28(x10)
P 00108693  # addi x13, x1, 1
P 00d686b3  # add  x13, x13, x13
P 402686b3  # sub  x13, x13, x2
P 0016c6b3  # xor  x13, x13, x1
P 02d52023  # sw   x13, 32(x10)
P 00852703  # lw   x14, 8(x10)
P 06470793  # addi x15, x14, 100
P 02f52223  # sw   x15, 36(x10)
P 00508013  # addi x0, x1, 5
P 02052423  # sw   x0, 40(x10)
P 00052803  # lw   x16, 0(x10)
P 03052623  # sw   x16, 44(x10)
P 00452883  # lw   x17, 4(x10)
P 03152823  # sw   x17, 48(x10)
P 02152a23  # sw   x1, 52(x10)
P 02252c23  # sw   x2, 56(x10)
P 00100073  # ebreak
E 1 00000200 00000004
E 1 00000204 0000000a
E 1 00000208 00000005
E 1 0000020c ffffffff
E 1 00000210 fffffffa
E 1 00000214 00000001
E 2 00000218 12344fff
E 2 0000021c fffff7ff
E 3 00000220 00000014
E 4 00000224 00000069
E 4 00000228 00000000
E 5 0000022c 00000004
E 5 00000230 0000000a
E 5 00000234 00000007
E 5 00000238 fffffffd

//--- compile.f
verilog/pcore_isa_pkg.sv
verilog/pcore_pipe_pkg.sv
verilog/fetch.sv
verilog/decode.sv
verilog/execute.sv
verilog/memory.sv
verilog/bus_arbiter.sv
verilog/pipeline_top.sv
dv/pipeline_tb.sv

//--- Makefile
LOG = sim.log

sim:
	verilator --binary --timing -f compile.f --top-module pipeline_tb -Mdir obj_dir
	obj_dir/Vpipeline_tb | tee $(LOG)
	grep -qx "No errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

//--- dv/pipeline_tb.sv
`timescale 1ns/10ps
`default_nettype none

module pipeline_tb;

    import pcore_isa_pkg::*;
    import pcore_pipe_pkg::*;

    localparam int MEM_WORDS = 256;

    logic          clk;
    logic          rst_i;
    type_bus_req_s bus_req_o;
    logic          bus_gnt_i;
    type_bus_rsp_s bus_rsp_i;
    logic          halt_o;

    logic [XLEN-1:0] mem [MEM_WORDS];
    int              exp_test [$];
    logic [XLEN-1:0] exp_addr [$];
    logic [XLEN-1:0] exp_data [$];

    int   seed;
    int   rand_mode;        // 0 gives minimum latency, 1 random
    int   prog_words;
    int   exp_total;
    int   stores_seen;
    int   test_stores;      // Stores of the test in progress
    int   test_err_base;
    int   errors;
    int   checks;
    logic stim_done;
    logic halted;

    pipeline_top u_dut (
        .clk       (clk),
        .rst_i     (rst_i),
        .bus_req_o (bus_req_o),
        .bus_gnt_i (bus_gnt_i),
        .bus_rsp_i (bus_rsp_i),
        .halt_o    (halt_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [XLEN-1:0] exp_v,
                               input logic [XLEN-1:0] act_v);
        checks++;
        if (exp_v !== act_v) begin
            $display("ERROR at %0t: %s expected %h, got %h", $time, name, exp_v, act_v);
            errors++;
        end
    endtask

    function automatic int pick_delay(input int lo, input int hi);
        if (rand_mode == 0)
            return lo;
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    function automatic string test_title(input int n);
        case (n)
            1: return "R-type ALU";
            2: return "LUI and immediates";
            3: return "dependency chain";
            4: return "load-use";
            5: return "bus back-pressure";
            6: return "halt";
            default: return "unknown";
        endcase
    endfunction

    task automatic report_test(input int n);
        int n_err;
        n_err = errors - test_err_base;
        $display("Test %0d (%s): %0d stores, %0d errors, %s", n, test_title(n),
                 test_stores, n_err, (n_err == 0) ? "PASS" : "FAIL");
        test_err_base = errors;
        test_stores   = 0;
    endtask

    // P, E and R lines; anything else up to the line end is skipped
    task automatic load_stim();
        int               fd;
        int               r;
        int               tnum;
        logic [7:0]       tag;
        logic [XLEN-1:0]  word;
        logic [XLEN-1:0]  addr;
        logic [8*128-1:0] rest;
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = ~{22'h0, 8'(i), 2'b00};    // Address-dependent fill
        fd = $fopen("dv/pipeline_stim.txt", "r");
        if (fd == 0) begin
            $display("Cannot open dv/pipeline_stim.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                r = $fscanf(fd, " %c", tag);
                if (r == 1) begin
                    case (tag)
                        "P": begin
                            r = $fscanf(fd, "%h", word);
                            mem[8'(prog_words)] = word;
                            prog_words++;
                        end
                        "E": begin
                            r = $fscanf(fd, "%d %h %h", tnum, addr, word);
                            exp_test.push_back(tnum);
                            exp_addr.push_back(addr);
                            exp_data.push_back(word);
                        end
                        "R": r = $fscanf(fd, "%d", rand_mode);
                        default: r = $fgets(rest, fd);
                    endcase
                end
            end
            $fclose(fd);
        end
        exp_total = exp_addr.size();
    endtask

    // Runs at the drive point, right after the edge that accepted req
    task automatic serve_request(input type_bus_req_s req);
        int              t;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] d;
        if (req.addr[XLEN-1:10] != '0) begin
            $display("Bus access at %0t to address %h outside the memory model",
                     $time, req.addr);
            errors++;
        end
        if (!req.we) begin
            bus_rsp_i.rdata = mem[req.addr[9:2]];
        end else begin
            mem[req.addr[9:2]] = req.wdata;
            bus_rsp_i.rdata    = '0;
            stores_seen++;
            test_stores++;
            if (halted) begin
                $display("Bus write at %0t to %h after halt_o rose", $time, req.addr);
                errors++;
            end
            if (exp_addr.size() == 0) begin
                $display("Unexpected store of %h to %h at %0t", req.wdata, req.addr, $time);
                errors++;
            end else begin
                t = exp_test.pop_front();
                a = exp_addr.pop_front();
                d = exp_data.pop_front();
                check_value("bus_req_o.addr", a, req.addr);
                check_value("bus_req_o.wdata", d, req.wdata);
                if (exp_test.size() == 0 || exp_test[0] != t)
                    report_test(t);
            end
        end
    endtask

    // Memory model on the shared bus
    initial begin : bus_model
        type_bus_req_s req;
        logic          accept;
        logic          rsp_done;
        logic          busy;
        int            rsp_cnt;
        int            gnt_wait;
        busy     = 1'b0;
        rsp_cnt  = 0;
        gnt_wait = 0;
        @(negedge rst_i);
        forever begin
            @(negedge clk);    // Everything settled here
            if (halt_o === 1'b1)
                halted = 1'b1;
            req      = bus_req_o;
            accept   = req.valid && bus_gnt_i;
            rsp_done = bus_rsp_i.valid;
            @(posedge clk);
            #0.5;
            bus_rsp_i.valid = 1'b0;
            if (rsp_done)
                busy = 1'b0;
            if (accept) begin
                serve_request(req);
                busy     = 1'b1;
                rsp_cnt  = pick_delay(1, 3) - 1;
                gnt_wait = pick_delay(0, 2);
            end else if (busy && rsp_cnt > 0) begin
                rsp_cnt--;
            end else if (!busy && gnt_wait > 0 && req.valid) begin
                gnt_wait--;    // Only counts while a request waits
            end
            bus_rsp_i.valid = busy && rsp_cnt == 0;
            bus_gnt_i       = !busy && gnt_wait == 0;
        end
    end

    initial begin : watchdog
        int limit;
        wait (stim_done === 1'b1);
        limit = 40 * prog_words + 200;
        repeat (limit) @(posedge clk);
        $display("Timeout after %0d cycles, the core never halted", limit);
        $display("Errors found");
        $finish;
    end

    initial begin : main
        rst_i         = 1'b1;
        bus_gnt_i     = 1'b0;
        bus_rsp_i     = '0;
        seed          = 32'h429e;
        rand_mode     = 0;
        prog_words    = 0;
        stores_seen   = 0;
        test_stores   = 0;
        test_err_base = 0;
        errors        = 0;
        checks        = 0;
        halted        = 1'b0;
        stim_done     = 1'b0;
        load_stim();
        stim_done = 1'b1;
        if (prog_words == 0) begin
            $display("No program words loaded from the stim file");
            errors++;
        end else begin
            repeat (3) @(posedge clk);
            #0.5;
            rst_i = 1'b0;
            while (halt_o !== 1'b1)
                @(negedge clk);
            // Window for stray writes after the halt
            repeat (10) begin
                @(negedge clk);
                if (halt_o !== 1'b1) begin
                    $display("halt_o dropped at %0t after it had risen", $time);
                    errors++;
                end
            end
            if (exp_addr.size() != 0) begin
                $display("%0d expected stores never appeared on the bus", exp_addr.size());
                errors++;
            end
            check_value("store count", exp_total, stores_seen);
            report_test(6);
        end
        $display("Done: %0d checks, %0d stores, %0d errors", checks, stores_seen, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule : pipeline_tb

`default_nettype wire

//--- verilog/pipeline_top.sv
`timescale 1ns/10ps
`default_nettype none

module pipeline_top (
    input  logic                          clk,
    input  logic                          rst_i,
    output pcore_pipe_pkg::type_bus_req_s bus_req_o,
    input  logic                          bus_gnt_i,
    input  pcore_pipe_pkg::type_bus_rsp_s bus_rsp_i,
    output logic                          halt_o
);

    import pcore_pipe_pkg::*;

    type_if2id_s   if2id;
    logic          id2if_rdy;
    type_id2exe_s  id2exe;
    logic          exe2id_rdy;
    type_exe2mem_s exe2mem;
    logic          mem2exe_rdy;
    type_wb2id_s   wb2id;

    // Per-master bus links into the arbiter
    type_bus_req_s ifu_bus_req;
    logic          ifu_bus_gnt;
    type_bus_rsp_s ifu_bus_rsp;
    type_bus_req_s lsu_bus_req;
    logic          lsu_bus_gnt;
    type_bus_rsp_s lsu_bus_rsp;

    fetch fetch_module (
        .clk           (clk),
        .rst_i         (rst_i),
        .ifu_bus_req_o (ifu_bus_req),
        .ifu_bus_gnt_i (ifu_bus_gnt),
        .ifu_bus_rsp_i (ifu_bus_rsp),
        .if2id_o       (if2id),
        .id2if_rdy_i   (id2if_rdy)
    );

    decode decode_module (
        .clk          (clk),
        .rst_i        (rst_i),
        .if2id_i      (if2id),
        .id2if_rdy_o  (id2if_rdy),
        .id2exe_o     (id2exe),
        .exe2id_rdy_i (exe2id_rdy),
        .wb2id_i      (wb2id)
    );

    execute execute_module (
        .clk           (clk),
        .rst_i         (rst_i),
        .id2exe_i      (id2exe),
        .exe2id_rdy_o  (exe2id_rdy),
        .exe2mem_o     (exe2mem),
        .mem2exe_rdy_i (mem2exe_rdy)
    );

    memory memory_module (
        .clk           (clk),
        .rst_i         (rst_i),
        .exe2mem_i     (exe2mem),
        .mem2exe_rdy_o (mem2exe_rdy),
        .lsu_bus_req_o (lsu_bus_req),
        .lsu_bus_gnt_i (lsu_bus_gnt),
        .lsu_bus_rsp_i (lsu_bus_rsp),
        .wb2id_o       (wb2id),
        .halt_o        (halt_o)
    );

    bus_arbiter bus_arbiter_module (
        .clk       (clk),
        .rst_i     (rst_i),
        .lsu_req_i (lsu_bus_req),
        .lsu_gnt_o (lsu_bus_gnt),
        .lsu_rsp_o (lsu_bus_rsp),
        .ifu_req_i (ifu_bus_req),
        .ifu_gnt_o (ifu_bus_gnt),
        .ifu_rsp_o (ifu_bus_rsp),
        .bus_req_o (bus_req_o),
        .bus_gnt_i (bus_gnt_i),
        .bus_rsp_i (bus_rsp_i)
    );

endmodule : pipeline_top

`default_nettype wire

//--- verilog/bus_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module bus_arbiter (
    input  logic                          clk,
    input  logic                          rst_i,
    input  pcore_pipe_pkg::type_bus_req_s lsu_req_i,
    output logic                          lsu_gnt_o,
    output pcore_pipe_pkg::type_bus_rsp_s lsu_rsp_o,
    input  pcore_pipe_pkg::type_bus_req_s ifu_req_i,
    output logic                          ifu_gnt_o,
    output pcore_pipe_pkg::type_bus_rsp_s ifu_rsp_o,
    output pcore_pipe_pkg::type_bus_req_s bus_req_o,
    input  logic                          bus_gnt_i,
    input  pcore_pipe_pkg::type_bus_rsp_s bus_rsp_i
);

    import pcore_pipe_pkg::*;

    logic          owned_q;    // Bus locked until the response returns
    logic          owner_lsu_q;
    logic          sel_lsu;
    type_bus_req_s sel_req;

    // Memory stage first, fetch otherwise
    assign sel_lsu = owned_q ? owner_lsu_q : lsu_req_i.valid;
    assign sel_req = sel_lsu ? lsu_req_i : ifu_req_i;

    always_comb begin
        bus_req_o       = sel_req;
        bus_req_o.valid = sel_req.valid && !owned_q;
    end

    assign lsu_gnt_o = !owned_q && sel_lsu && bus_gnt_i;
    assign ifu_gnt_o = !owned_q && !sel_lsu && bus_gnt_i;

    assign lsu_rsp_o = '{valid: owned_q && owner_lsu_q && bus_rsp_i.valid,
                         rdata: bus_rsp_i.rdata};
    assign ifu_rsp_o = '{valid: owned_q && !owner_lsu_q && bus_rsp_i.valid,
                         rdata: bus_rsp_i.rdata};

    always_ff @(posedge clk) begin
        if (rst_i) begin
            owned_q     <= 1'b0;
            owner_lsu_q <= 1'b0;
        end else if (owned_q) begin
            if (bus_rsp_i.valid)
                owned_q <= 1'b0;
        end else if (bus_req_o.valid && bus_gnt_i) begin
            owned_q     <= 1'b1;
            owner_lsu_q <= sel_lsu;
        end
    end

endmodule : bus_arbiter

`default_nettype wire

//--- verilog/memory.sv
`timescale 1ns/10ps
`default_nettype none

module memory (
    input  logic                          clk,
    input  logic                          rst_i,
    input  pcore_pipe_pkg::type_exe2mem_s exe2mem_i,
    output logic                          mem2exe_rdy_o,
    output pcore_pipe_pkg::type_bus_req_s lsu_bus_req_o,
    input  logic                          lsu_bus_gnt_i,
    input  pcore_pipe_pkg::type_bus_rsp_s lsu_bus_rsp_i,
    output pcore_pipe_pkg::type_wb2id_s   wb2id_o,
    output logic                          halt_o
);

    import pcore_pipe_pkg::*;

    logic mem_op;
    logic sent_q;    // Bus request accepted, waiting for its response
    logic done;
    logic halt_q;

    assign mem_op = exe2mem_i.valid && (exe2mem_i.is_load || exe2mem_i.is_store);
    assign done   = !mem_op || (sent_q && lsu_bus_rsp_i.valid);

    assign lsu_bus_req_o = '{valid: mem_op && !sent_q, we: exe2mem_i.is_store,
                             addr: exe2mem_i.result, wdata: exe2mem_i.store_data};

    assign mem2exe_rdy_o = done;

    assign wb2id_o.we   = exe2mem_i.valid && done && exe2mem_i.rd_we;
    assign wb2id_o.rd   = exe2mem_i.rd;
    assign wb2id_o.data = exe2mem_i.is_load ? lsu_bus_rsp_i.rdata : exe2mem_i.result;

    assign halt_o = halt_q || (exe2mem_i.valid && exe2mem_i.is_halt);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            sent_q <= 1'b0;
            halt_q <= 1'b0;
        end else begin
            if (lsu_bus_req_o.valid && lsu_bus_gnt_i)
                sent_q <= 1'b1;
            else if (sent_q && lsu_bus_rsp_i.valid)
                sent_q <= 1'b0;
            if (exe2mem_i.valid && exe2mem_i.is_halt)
                halt_q <= 1'b1;    // Sticky
        end
    end

endmodule : memory

`default_nettype wire

//--- verilog/execute.sv
`timescale 1ns/10ps
`default_nettype none

module execute (
    input  logic                          clk,
    input  logic                          rst_i,
    input  pcore_pipe_pkg::type_id2exe_s  id2exe_i,
    output logic                          exe2id_rdy_o,
    output pcore_pipe_pkg::type_exe2mem_s exe2mem_o,
    input  logic                          mem2exe_rdy_i
);

    import pcore_isa_pkg::*;
    import pcore_pipe_pkg::*;

    logic [XLEN-1:0] alu_res;
    type_exe2mem_s   exe2mem_q;

    always_comb begin
        case (id2exe_i.alu_op)
            ALU_ADD:    alu_res = id2exe_i.op_a + id2exe_i.op_b;    // Also load/store address
            ALU_SUB:    alu_res = id2exe_i.op_a - id2exe_i.op_b;
            ALU_AND:    alu_res = id2exe_i.op_a & id2exe_i.op_b;
            ALU_OR:     alu_res = id2exe_i.op_a | id2exe_i.op_b;
            ALU_XOR:    alu_res = id2exe_i.op_a ^ id2exe_i.op_b;
            ALU_SLT:    alu_res = {{(XLEN-1){1'b0}},
                                   $signed(id2exe_i.op_a) < $signed(id2exe_i.op_b)};
            ALU_PASS_B: alu_res = id2exe_i.op_b;
            default:    alu_res = '0;
        endcase
    end

    assign exe2id_rdy_o = !exe2mem_q.valid || mem2exe_rdy_i;
    assign exe2mem_o    = exe2mem_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            exe2mem_q.valid <= 1'b0;
        end else if (id2exe_i.valid && exe2id_rdy_o) begin
            exe2mem_q.valid      <= 1'b1;
            exe2mem_q.result     <= alu_res;
            exe2mem_q.store_data <= id2exe_i.store_data;
            exe2mem_q.rd         <= id2exe_i.rd;
            exe2mem_q.rd_we      <= id2exe_i.rd_we;
            exe2mem_q.is_load    <= id2exe_i.is_load;
            exe2mem_q.is_store   <= id2exe_i.is_store;
            exe2mem_q.is_halt    <= id2exe_i.is_halt;
        end else if (mem2exe_rdy_i) begin
            exe2mem_q.valid <= 1'b0;
        end
    end

endmodule : execute

`default_nettype wire

//--- verilog/decode.sv
`timescale 1ns/10ps
`default_nettype none

module decode (
    input  logic                         clk,
    input  logic                         rst_i,
    input  pcore_pipe_pkg::type_if2id_s  if2id_i,
    output logic                         id2if_rdy_o,
    output pcore_pipe_pkg::type_id2exe_s id2exe_o,
    input  logic                         exe2id_rdy_i,
    input  pcore_pipe_pkg::type_wb2id_s  wb2id_i
);

    import pcore_isa_pkg::*;
    import pcore_pipe_pkg::*;

    localparam int NREGS = 2**RF_AWIDTH;

    type_instr_u       instr;
    logic [XLEN-1:0]   rf_q [NREGS];
    logic [NREGS-1:0]  sb_q;       // Pending write per register
    logic [NREGS-1:0]  sb_live;    // Same, minus this cycle's writeback
    logic [XLEN-1:0]   rs1_data;
    logic [XLEN-1:0]   rs2_data;
    logic              use_rs1;
    logic              use_rs2;
    logic              writes_rd;
    logic              hazard;
    logic              issue;
    type_id2exe_s      dec;
    type_id2exe_s      id2exe_q;

    // Writeback in the same cycle wins over the array
    function automatic logic [XLEN-1:0] rf_read(input logic [RF_AWIDTH-1:0] addr);
        if (addr == '0)
            return '0;
        if (wb2id_i.we && wb2id_i.rd == addr)
            return wb2id_i.data;
        return rf_q[addr];
    endfunction

    function automatic type_alu_op_e alu_sel(input logic [2:0] f3);
        case (f3)
            F3_SLT:  return ALU_SLT;
            F3_XOR:  return ALU_XOR;
            F3_OR:   return ALU_OR;
            F3_AND:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    assign instr = if2id_i.instr;

    always_comb begin
        rs1_data       = rf_read(instr.r.rs1);
        rs2_data       = rf_read(instr.r.rs2);
        use_rs1        = 1'b0;
        use_rs2        = 1'b0;
        writes_rd      = 1'b0;
        dec            = '0;
        dec.valid      = 1'b1;
        dec.alu_op     = ALU_ADD;
        dec.op_a       = rs1_data;
        dec.op_b       = {{20{instr.i.imm[11]}}, instr.i.imm};    // I-type default
        dec.store_data = rs2_data;
        dec.rd         = instr.r.rd;
        case (instr.r.opcode)
            OPC_LUI: begin
                dec.alu_op = ALU_PASS_B;
                dec.op_b   = {instr.u.imm, 12'b0};
                writes_rd  = 1'b1;
            end
            OPC_OPIMM: begin
                dec.alu_op = alu_sel(instr.i.funct3);
                use_rs1    = 1'b1;
                writes_rd  = 1'b1;
            end
            OPC_OP: begin
                dec.op_b   = rs2_data;
                dec.alu_op = (instr.r.funct3 == F3_ADD && instr.r.funct7 == F7_SUB) ?
                             ALU_SUB : alu_sel(instr.r.funct3);
                use_rs1    = 1'b1;
                use_rs2    = 1'b1;
                writes_rd  = 1'b1;
            end
            OPC_LOAD: begin
                dec.is_load = 1'b1;
                use_rs1     = 1'b1;
                writes_rd   = 1'b1;
            end
            OPC_STORE: begin
                dec.op_b     = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
                dec.is_store = 1'b1;
                use_rs1      = 1'b1;
                use_rs2      = 1'b1;
            end
            OPC_SYSTEM: dec.is_halt = (if2id_i.instr == INSTR_EBREAK);
            default: ;    // Unsupported, flows through as a no-op
        endcase
        dec.rd_we = writes_rd && (instr.r.rd != '0);
    end

    always_comb begin
        sb_live = sb_q;
        if (wb2id_i.we)
            sb_live[wb2id_i.rd] = 1'b0;
    end

    // WAW also stalls so a single pending bit per register is enough
    assign hazard = (use_rs1 && sb_live[instr.r.rs1]) ||
                    (use_rs2 && sb_live[instr.r.rs2]) ||
                    (dec.rd_we && sb_live[instr.r.rd]);

    assign id2if_rdy_o = !hazard && (!id2exe_q.valid || exe2id_rdy_i);
    assign issue       = if2id_i.valid && id2if_rdy_o;
    assign id2exe_o    = id2exe_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            sb_q           <= '0;
            id2exe_q.valid <= 1'b0;
        end else begin
            sb_q <= sb_live;
            if (issue) begin
                id2exe_q <= dec;
                if (dec.rd_we)
                    sb_q[dec.rd] <= 1'b1;    // Set beats the clear above
            end else if (exe2id_rdy_i) begin
                id2exe_q.valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wb2id_i.we && wb2id_i.rd != '0)
            rf_q[wb2id_i.rd] <= wb2id_i.data;
    end

endmodule : decode

`default_nettype wire

//--- verilog/fetch.sv
`timescale 1ns/10ps
`default_nettype none

module fetch (
    input  logic                          clk,
    input  logic                          rst_i,
    output pcore_pipe_pkg::type_bus_req_s ifu_bus_req_o,
    input  logic                          ifu_bus_gnt_i,
    input  pcore_pipe_pkg::type_bus_rsp_s ifu_bus_rsp_i,
    output pcore_pipe_pkg::type_if2id_s   if2id_o,
    input  logic                          id2if_rdy_i
);

    import pcore_isa_pkg::*;
    import pcore_pipe_pkg::*;

    logic [XLEN-1:0] pc_q;
    logic            pend_q;      // Request accepted, response outstanding
    logic            halt_q;      // EBREAK fetched
    logic            run_q;       // First cycle out of reset has passed
    logic            take;
    logic            req_vld;
    type_if2id_s     if2id_q;

    assign take    = if2id_q.valid && id2if_rdy_i;
    assign req_vld = run_q && !halt_q && !pend_q && (!if2id_q.valid || take);

    assign ifu_bus_req_o = '{valid: req_vld, we: 1'b0, addr: pc_q, wdata: '0};
    assign if2id_o       = if2id_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q          <= '0;
            pend_q        <= 1'b0;
            halt_q        <= 1'b0;
            run_q         <= 1'b0;
            if2id_q.valid <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (req_vld && ifu_bus_gnt_i) begin
                pc_q   <= pc_q + XLEN'(4);
                pend_q <= 1'b1;
            end
            if (take)
                if2id_q.valid <= 1'b0;
            if (pend_q && ifu_bus_rsp_i.valid) begin
                pend_q        <= 1'b0;
                if2id_q.valid <= 1'b1;
                if2id_q.instr <= ifu_bus_rsp_i.rdata;
                if2id_q.pc    <= pc_q - XLEN'(4);    // PC already stepped at grant
                if (ifu_bus_rsp_i.rdata == INSTR_EBREAK)
                    halt_q <= 1'b1;
            end
        end
    end

endmodule : fetch

`default_nettype wire

//--- verilog/pcore_pipe_pkg.sv
`default_nettype none

package pcore_pipe_pkg;

    import pcore_isa_pkg::*;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B    // LUI result
    } type_alu_op_e;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } type_if2id_s;

    typedef struct packed {
        logic                 valid;
        type_alu_op_e         alu_op;
        logic [XLEN-1:0]      op_a;
        logic [XLEN-1:0]      op_b;
        logic [XLEN-1:0]      store_data;
        logic [RF_AWIDTH-1:0] rd;
        logic                 rd_we;
        logic                 is_load;
        logic                 is_store;
        logic                 is_halt;
    } type_id2exe_s;

    typedef struct packed {
        logic                 valid;
        logic [XLEN-1:0]      result;    // Data address for loads and stores
        logic [XLEN-1:0]      store_data;
        logic [RF_AWIDTH-1:0] rd;
        logic                 rd_we;
        logic                 is_load;
        logic                 is_store;
        logic                 is_halt;
    } type_exe2mem_s;

    typedef struct packed {
        logic                 we;
        logic [RF_AWIDTH-1:0] rd;
        logic [XLEN-1:0]      data;
    } type_wb2id_s;

    // Shared memory bus
    typedef struct packed {
        logic            valid;
        logic            we;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
    } type_bus_req_s;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] rdata;
    } type_bus_rsp_s;

endpackage

`default_nettype wire

//--- verilog/pcore_isa_pkg.sv
`default_nettype none

package pcore_isa_pkg;

    localparam int XLEN      = 32;
    localparam int RF_AWIDTH = 5;

    // Major opcodes of the supported subset
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam logic [2:0] F3_ADD = 3'b000;    // SUB shares it
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [6:0] F7_SUB = 7'b0100000;

    localparam logic [XLEN-1:0] INSTR_EBREAK = 32'h0010_0073;

    typedef struct packed {
        logic [6:0]           funct7;
        logic [RF_AWIDTH-1:0] rs2;
        logic [RF_AWIDTH-1:0] rs1;
        logic [2:0]           funct3;
        logic [RF_AWIDTH-1:0] rd;
        logic [6:0]           opcode;
    } type_r_fmt_s;

    typedef struct packed {
        logic [11:0]          imm;
        logic [RF_AWIDTH-1:0] rs1;
        logic [2:0]           funct3;
        logic [RF_AWIDTH-1:0] rd;
        logic [6:0]           opcode;
    } type_i_fmt_s;

    typedef struct packed {
        logic [6:0]           imm_hi;
        logic [RF_AWIDTH-1:0] rs2;
        logic [RF_AWIDTH-1:0] rs1;
        logic [2:0]           funct3;
        logic [4:0]           imm_lo;
        logic [6:0]           opcode;
    } type_s_fmt_s;

    typedef struct packed {
        logic [19:0]          imm;
        logic [RF_AWIDTH-1:0] rd;
        logic [6:0]           opcode;
    } type_u_fmt_s;

    // One instruction word, four ways to read it
    typedef union packed {
        type_r_fmt_s r;
        type_i_fmt_s i;
        type_s_fmt_s s;
        type_u_fmt_s u;
    } type_instr_u;

endpackage

`default_nettype wire
